// File: bench/hist_patterns.txt
// one 5 digit hex word per line: kind, pixel, bin, count (2 digits)
// kind 1 event in bin, 2 expected count of pixel and bin, 3 end of histogram, 4 reread previous
10300
10300
10700
10200
10f00
10f00
10000
10900
10300
10500
10700
10700
10100
10f00
10000
10000
10300
10300
10200
10c00
10f00
10400
10900
10000
20305
20501
21703
21202
21c01
22f04
22101
22401
23004
23902
30000
10a00
10a00
10000
10100
10600
10600
10e00
10d00
10a00
10b00
10100
10100
40000
10600
10800
10e00
10e00
10a00
10a00
10000
10f00
10800
10800
10d00
10e00
20a05
20b01
21002
21103
21f01
22603
22803
23e04
23d02
30000

// File: vlog.f
logic/hist_pkg.sv
logic/acq_counter.sv
logic/hist_ctrl.sv
logic/hist_bank.sv
logic/hist_builder.sv
bench/tb_clock.sv
bench/hist_tb.sv

// File: run_verilator.sh
#!/bin/sh
# build and run the histogram testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert -sv --top-module hist_tb -f vlog.f \
    && ./obj_dir/Vhist_tb; } > sim.log 2>&1 || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// File: bench/hist_tb.sv
`timescale 1ns/1ps

module hist_tb;
    import hist_pkg::*;

    localparam int PAT_MAX = 256;
    localparam int HIST_EV = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    // top hex digit of a pattern word
    localparam logic [3:0] K_EVENT = 4'h1;
    localparam logic [3:0] K_CHECK = 4'h2;
    localparam logic [3:0] K_SWAP = 4'h3;
    localparam logic [3:0] K_PREV = 4'h4;

    logic               clk;
    logic               res;
    logic               wr_en;
    logic [NB-1:0]      bin;
    logic [ADDR_W-1:0]  rd_addr;
    logic [COUNT_W-1:0] rd_data;
    logic               busy;
    logic               hist_done;
    logic               hist_num;

    logic [19:0]   pat [PAT_MAX];
    // fill histogram, finished histogram, expected readback
    int            model_cnt [DEPTH];
    int            prev_cnt [DEPTH];
    int            exp_cnt [DEPTH];
    logic [31:0]   lcg_state = 32'he533;
    logic [NB-1:0] last_bin = '0;
    // bank being filled as the model sees it
    logic          exp_num = 1'b0;
    int            errors = 0;
    int            checks = 0;
    int            hist_events = 0;
    int            done_in_hist = 0;
    int            check_sum = 0;
    int            limit_cycles = 0;
    logic          limit_ready = 1'b0;

    tb_clock clk_gen_i (
        .clk (clk)
    );

    hist_builder dut_i (
        .clk       (clk),
        .res       (res),
        .wr_en     (wr_en),
        .bin       (bin),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy),
        .hist_done (hist_done),
        .hist_num  (hist_num)
    );

    function automatic logic [31:0] lcg_step();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // one accepted event with its pixel taken from the event order
    task automatic send_event(input logic [NB-1:0] b);
        logic [31:0]       r;
        int                gap;
        logic [ADDR_W-1:0] addr;
        logic              is_last;
        r = lcg_step();
        gap = int'(r[17:16]);
        // a repeated bin goes back to back to hit the forwarding path
        if (hist_events > 0 && b == last_bin) begin
            gap = 0;
        end
        repeat (gap) @(negedge clk);
        checks++;
        assert (!busy) else begin
            $display("DUT still busy when event %0d was due", hist_events);
            errors++;
        end
        addr = {PIX_W'((hist_events / DATA_NUM) % PIXEL_NUM), b};
        hist_events++;
        is_last = (hist_events == HIST_EV);
        if (is_last) begin
            exp_num = ~exp_num;
        end
        wr_en = 1'b1;
        bin = b;
        last_bin = b;
        model_cnt[addr]++;
        // comb pulse settles mid cycle
        #1;
        checks++;
        assert (hist_done === is_last) else begin
            $display("Error: hist_done at event %0d got %h expected %h",
                     hist_events, hist_done, is_last);
            errors++;
        end
        if (hist_done === 1'b1) begin
            done_in_hist++;
        end
        @(negedge clk);
        wr_en = 1'b0;
        checks++;
        assert (hist_num === exp_num) else begin
            $display("Error: hist_num got %h expected %h", hist_num, exp_num);
            errors++;
        end
    endtask

    // strobes only in cycles where busy is high
    task automatic drop_while_busy(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = lcg_step();
            if (busy) begin
                wr_en = 1'b1;
                bin = r[23:20];
            end
            @(negedge clk);
            wr_en = 1'b0;
        end
        while (busy) @(negedge clk);
    endtask

    // pipelined read of every address against exp_cnt
    task automatic read_compare();
        rd_addr = '0;
        for (int a = 0; a < DEPTH; a++) begin
            @(negedge clk);
            checks++;
            assert (rd_data === COUNT_W'(exp_cnt[a])) else begin
                $display("Error: rd_data at addr %h got %h expected %h",
                         a, rd_data, exp_cnt[a]);
                errors++;
            end
            if (a < DEPTH - 1) begin
                rd_addr = ADDR_W'(a + 1);
            end
        end
    endtask

    task automatic finish_hist();
        checks++;
        assert (hist_events == HIST_EV && done_in_hist == 1) else begin
            $display("histogram ended after %0d events with %0d done pulses",
                     hist_events, done_in_hist);
            errors++;
        end
        checks++;
        assert (check_sum == HIST_EV) else begin
            $display("check lines cover %0d counts, not %0d", check_sum, HIST_EV);
            errors++;
        end
        // these strobes land while the new fill bank is swept
        drop_while_busy(8);
        exp_cnt = model_cnt;
        read_compare();
        prev_cnt = model_cnt;
        for (int a = 0; a < DEPTH; a++) begin
            model_cnt[a] = 0;
        end
        hist_events = 0;
        done_in_hist = 0;
        check_sum = 0;
    endtask

    initial begin
        logic [ADDR_W-1:0] chk_addr;
        int                n_reads;
        res = 1'b0;
        wr_en = 1'b0;
        bin = '0;
        rd_addr = '0;
        for (int i = 0; i < PAT_MAX; i++) begin
            pat[i] = '0;
        end
        for (int a = 0; a < DEPTH; a++) begin
            model_cnt[a] = 0;
            exp_cnt[a] = 0;
        end
        $readmemh("bench/hist_patterns.txt", pat);
        // run length from the pattern file
        n_reads = 1;
        for (int i = 0; i < PAT_MAX; i++) begin
            if (pat[i][19:16] == K_EVENT) begin
                limit_cycles += 5;
            end else if (pat[i][19:16] == K_SWAP || pat[i][19:16] == K_PREV) begin
                n_reads++;
            end
        end
        limit_cycles += 4 * DEPTH + n_reads * (DEPTH + 2);
        limit_ready = 1'b1;
        repeat (2) @(negedge clk);
        res = 1'b1;
        checks++;
        assert (busy === 1'b1 && hist_done === 1'b0 && hist_num === 1'b0) else begin
            $display("Error: after reset busy %h hist_done %h hist_num %h expected 1 0 0",
                     busy, hist_done, hist_num);
            errors++;
        end
        drop_while_busy(6);
        read_compare();
        for (int i = 0; i < PAT_MAX && pat[i][19:16] != 4'h0; i++) begin
            case (pat[i][19:16])
                K_EVENT: send_event(pat[i][11:8]);
                K_CHECK: begin
                    chk_addr = {PIX_W'(pat[i][15:12]), pat[i][11:8]};
                    check_sum += int'(pat[i][7:0]);
                    checks++;
                    assert (model_cnt[chk_addr] == int'(pat[i][7:0])) else begin
                        $display("Error: model_cnt at addr %h got %h expected %h",
                                 chk_addr, model_cnt[chk_addr], pat[i][7:0]);
                        errors++;
                    end
                end
                K_SWAP: finish_hist();
                K_PREV: begin
                    // finished bank still readable mid fill
                    exp_cnt = prev_cnt;
                    read_compare();
                end
                default: begin
                    $display("unknown pattern word %h at line %0d", pat[i], i);
                    errors++;
                end
            endcase
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_ready);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", limit_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

// File: logic/hist_builder.sv
`timescale 1ns/1ps

module hist_builder (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         wr_en,
    input  logic [hist_pkg::NB-1:0]      bin,
    input  logic [hist_pkg::ADDR_W-1:0]  rd_addr,
    output logic [hist_pkg::COUNT_W-1:0] rd_data,
    output logic                         busy,
    output logic                         hist_done,
    output logic                         hist_num
);
    import hist_pkg::*;

    logic               ev;
    logic               last_ev;
    logic [PIX_W-1:0]   pixel;
    logic               inc0;
    logic               inc1;
    logic               clr0;
    logic               clr1;
    logic [ADDR_W-1:0]  clr_addr;
    logic [ADDR_W-1:0]  inc_addr;
    logic [COUNT_W-1:0] rd_data0;
    logic [COUNT_W-1:0] rd_data1;
    logic               rd_sel;

    // word of the current event
    assign inc_addr = {pixel, bin};

    hist_ctrl ctrl_i (
        .clk       (clk),
        .res       (res),
        .wr_en     (wr_en),
        .last_ev   (last_ev),
        .ev        (ev),
        .busy      (busy),
        .hist_done (hist_done),
        .hist_num  (hist_num),
        .inc0      (inc0),
        .inc1      (inc1),
        .clr0      (clr0),
        .clr1      (clr1),
        .clr_addr  (clr_addr)
    );

    acq_counter cnt_i (
        .clk     (clk),
        .res     (res),
        .ev      (ev),
        .pixel   (pixel),
        .last_ev (last_ev)
    );

    hist_bank bank0_i (
        .clk      (clk),
        .res      (res),
        .inc      (inc0),
        .inc_addr (inc_addr),
        .clr      (clr0),
        .clr_addr (clr_addr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data0)
    );

    hist_bank bank1_i (
        .clk      (clk),
        .res      (res),
        .inc      (inc1),
        .inc_addr (inc_addr),
        .clr      (clr1),
        .clr_addr (clr_addr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data1)
    );

    // fill bank at the time of the read, aligned with bank read latency
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_sel <= 1'b0;
        end else begin
            rd_sel <= hist_num;
        end
    end

    // readout from the finished bank
    assign rd_data = rd_sel ? rd_data0 : rd_data1;

endmodule

// File: logic/hist_bank.sv
`timescale 1ns/1ps

module hist_bank (
    input  logic                         clk,
    input  logic                         res,
    input  logic                         inc,
    input  logic [hist_pkg::ADDR_W-1:0]  inc_addr,
    input  logic                         clr,
    input  logic [hist_pkg::ADDR_W-1:0]  clr_addr,
    input  logic [hist_pkg::ADDR_W-1:0]  rd_addr,
    output logic [hist_pkg::COUNT_W-1:0] rd_data
);
    import hist_pkg::*;

    // one count per pixel and bin
    logic [COUNT_W-1:0] mem [DEPTH];

    // pending write of the increment pipeline
    logic               wr_pend;
    logic [ADDR_W-1:0]  wr_addr;
    logic [COUNT_W-1:0] wr_val;

    // same address as the pending write
    logic               fwd;
    logic [COUNT_W-1:0] base;

    assign fwd = wr_pend && (wr_addr == inc_addr);

    // count before this event
    // back to back hit takes the value not yet written
    assign base = fwd ? (wr_val + 1'b1) : mem[inc_addr];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= inc;
        end
    end

    // address and old count, held for the write cycle
    always_ff @(posedge clk) begin
        if (inc) begin
            wr_addr <= inc_addr;
            wr_val <= base;
        end
    end

    // single write port
    // clear and increment never overlap in one bank
    always_ff @(posedge clk) begin
        if (clr) begin
            mem[clr_addr] <= '0;
        end else if (wr_pend) begin
            mem[wr_addr] <= wr_val + 1'b1;
        end
    end

    // readout port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // controller keeps increments and clears apart
    a_inc_clr: assert property (
        @(posedge clk) disable iff (!res)
        !(inc && clr)
    ) else $error("inc and clr together at %0h / %0h", inc_addr, clr_addr);

    // a clear right behind an increment would drop its write
    a_no_lost_write: assert property (
        @(posedge clk) disable iff (!res)
        inc |=> !clr
    ) else $error("clear drops pending write at %0h", wr_addr);

endmodule

// File: logic/hist_ctrl.sv
`timescale 1ns/1ps

module hist_ctrl (
    input  logic                        clk,
    input  logic                        res,
    input  logic                        wr_en,
    input  logic                        last_ev,
    output logic                        ev,
    output logic                        busy,
    output logic                        hist_done,
    output logic                        hist_num,
    output logic                        inc0,
    output logic                        inc1,
    output logic                        clr0,
    output logic                        clr1,
    output logic [hist_pkg::ADDR_W-1:0] clr_addr
);
    import hist_pkg::*;

    logic [1:0]        state;
    logic [ADDR_W-1:0] clr_cnt;
    logic              clr_last;
    logic              fill_clr;

    // sweep timer reaches the last word
    assign clr_last = (clr_cnt == ADDR_W'(DEPTH - 1));

    // both clear states hold off new events
    assign busy = (state != ST_ACQUIRE);

    // events only count while acquiring
    assign ev = wr_en && (state == ST_ACQUIRE);

    // pulse in the accept cycle of the final event
    // swap takes effect on the same edge
    assign hist_done = last_ev;

    // increments go to the fill bank only
    assign inc0 = ev && !hist_num;
    assign inc1 = ev && hist_num;

    // after reset both banks are swept
    // after a swap only the new fill bank
    assign fill_clr = (state == ST_CLEAR_FILL);
    assign clr0 = (state == ST_CLEAR_ALL) || (fill_clr && !hist_num);
    assign clr1 = (state == ST_CLEAR_ALL) || (fill_clr && hist_num);
    assign clr_addr = clr_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= ST_CLEAR_ALL;
            clr_cnt <= '0;
            hist_num <= 1'b0;
        end else begin
            case (state)
                ST_CLEAR_ALL, ST_CLEAR_FILL: begin
                    // one word per cycle for DEPTH cycles
                    if (clr_last) begin
                        clr_cnt <= '0;
                        state <= ST_ACQUIRE;
                    end else begin
                        clr_cnt <= clr_cnt + 1'b1;
                    end
                end
                ST_ACQUIRE: begin
                    // last event accepted so the banks swap
                    if (last_ev) begin
                        hist_num <= ~hist_num;
                        state <= ST_CLEAR_FILL;
                    end
                end
                default: begin
                    state <= ST_CLEAR_ALL;
                    clr_cnt <= '0;
                end
            endcase
        end
    end

    // last_ev from the counter is only legal while acquiring
    a_done_not_busy: assert property (
        @(posedge clk) disable iff (!res)
        !(hist_done && busy)
    ) else $error("hist_done %0h while busy, state %0h", hist_done, state);

endmodule

// File: logic/acq_counter.sv
`timescale 1ns/1ps

module acq_counter (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       ev,
    output logic [hist_pkg::PIX_W-1:0] pixel,
    output logic                       last_ev
);
    import hist_pkg::*;

    // event within pixel, pixel within acquisition, acquisition within histogram
    logic [EV_W-1:0]  ev_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;

    // each counter at its last value
    logic ev_wrap;
    logic pix_wrap;
    logic acq_wrap;

    assign ev_wrap = (ev_cnt == EV_W'(DATA_NUM - 1));
    assign pix_wrap = (pix_cnt == PIX_W'(PIXEL_NUM - 1));
    assign acq_wrap = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    // pixel of the event in flight before the counters advance
    assign pixel = pix_cnt;

    // final event of the whole histogram
    assign last_ev = ev && ev_wrap && pix_wrap && acq_wrap;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ev_cnt <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (ev) begin
            if (ev_wrap) begin
                ev_cnt <= '0;
                // pixel done so move on to the next one
                if (pix_wrap) begin
                    pix_cnt <= '0;
                    // acquisition done
                    if (acq_wrap) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                ev_cnt <= ev_cnt + 1'b1;
            end
        end
    end

    // acq counter has a spare code that must stay unused
    a_cnt_range: assert property (
        @(posedge clk) disable iff (!res)
        acq_cnt <= ACQ_W'(ACQ_NUM - 1)
    ) else $error("acq_counter out of range acq %0h", acq_cnt);

endmodule

// File: logic/hist_pkg.sv
package hist_pkg;

    // one time bin from the tdc
    localparam int NB = 4;
    localparam int BIN_NUM = 16;

    // acquisition order: events per pixel, pixels, acquisitions
    localparam int DATA_NUM = 2;
    localparam int EV_W = 1;
    localparam int PIXEL_NUM = 4;
    localparam int PIX_W = 2;
    localparam int ACQ_NUM = 3;
    localparam int ACQ_W = 2;

    // bank word address is {pixel, bin}
    localparam int ADDR_W = PIX_W + NB;
    localparam int DEPTH = PIXEL_NUM * BIN_NUM;

    // max count per bin is DATA_NUM * ACQ_NUM, no overflow possible
    localparam int COUNT_W = 8;

    // controller state codes
    localparam logic [1:0] ST_CLEAR_ALL = 2'd0;
    localparam logic [1:0] ST_ACQUIRE = 2'd1;
    localparam logic [1:0] ST_CLEAR_FILL = 2'd2;

endpackage
